// ==== design/lsu_macros.svh ====
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data path width, one rv64 register
`define LSU_XLEN 64

// address bits seen by the data ram
`define LSU_ADDR_W 32

// register index width
`define LSU_REG_W 5

// ram depth in 64-bit words
`define LSU_RAM_WORDS 256

// input queue depth
// also the credits execute starts with
`define LSU_IN_DEPTH 4

// credits the writeback consumer grants after reset
`define LSU_WB_CREDITS 2

// derived widths
// word index into the ram, taken above the byte offset
`define LSU_RAM_IDX_W ($clog2(`LSU_RAM_WORDS))
// queue pointers
`define LSU_IN_PTR_W ($clog2(`LSU_IN_DEPTH))
// queue occupancy, has to reach the full depth
`define LSU_IN_CNT_W ($clog2(`LSU_IN_DEPTH + 1))
// writeback credit counter
`define LSU_WB_CNT_W ($clog2(`LSU_WB_CREDITS + 1))

`endif

// ==== design/lsu_pkg.sv ====
package lsu_pkg;

  // memory opcodes coming from execute
  // none means the op only carries an alu result
  typedef enum logic [3:0] {
    MEMOP_NONE = 4'd0,
    MEMOP_LB   = 4'd1,
    MEMOP_LBU  = 4'd2,
    MEMOP_LH   = 4'd3,
    MEMOP_LHU  = 4'd4,
    MEMOP_LW   = 4'd5,
    MEMOP_LWU  = 4'd6,
    MEMOP_LD   = 4'd7,
    MEMOP_SB   = 4'd8,
    MEMOP_SH   = 4'd9,
    MEMOP_SW   = 4'd10,
    MEMOP_SD   = 4'd11
  } mem_op_e;

  // request stage: idle, or holding a ram request
  typedef enum logic {
    REQ_IDLE,
    REQ_WAIT
  } req_state_e;

  // ram sequencer: accept, one busy cycle, respond
  typedef enum logic [1:0] {
    RAM_IDLE,
    RAM_BUSY,
    RAM_RESP
  } ram_state_e;

endpackage

// ==== design/lsu_in_fifo.sv ====
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_in_fifo (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   push_i,
  input  lsu_pkg::mem_op_e       push_op_i,
  input  logic [`LSU_REG_W-1:0]  push_rd_i,
  input  logic [`LSU_XLEN-1:0]   push_alu_i,
  input  logic [`LSU_XLEN-1:0]   push_rs2_i,
  input  logic                   pop_i,
  output logic                   valid_o,
  output lsu_pkg::mem_op_e       op_o,
  output logic [`LSU_REG_W-1:0]  rd_o,
  output logic [`LSU_XLEN-1:0]   alu_o,
  output logic [`LSU_XLEN-1:0]   rs2_o,
  output logic                   credit_o
);
  import lsu_pkg::*;

  mem_op_e                  op_mem  [`LSU_IN_DEPTH];
  logic [`LSU_REG_W-1:0]    rd_mem  [`LSU_IN_DEPTH];
  logic [`LSU_XLEN-1:0]     alu_mem [`LSU_IN_DEPTH];
  logic [`LSU_XLEN-1:0]     rs2_mem [`LSU_IN_DEPTH];
  logic [`LSU_IN_PTR_W-1:0] wr_ptr_q;
  logic [`LSU_IN_PTR_W-1:0] rd_ptr_q;
  logic [`LSU_IN_CNT_W-1:0] count_q;
  logic                     pop_ok;

  // head is valid whenever something is stored
  assign valid_o = (count_q != '0);
  assign pop_ok  = pop_i & valid_o;
  // one credit back to execute per entry freed
  assign credit_o = pop_ok;

  assign op_o  = op_mem[rd_ptr_q];
  assign rd_o  = rd_mem[rd_ptr_q];
  assign alu_o = alu_mem[rd_ptr_q];
  assign rs2_o = rs2_mem[rd_ptr_q];

  // entry storage
  // execute never pushes without a credit, so no full check
  always_ff @(posedge clk) begin
    if (push_i) begin
      op_mem[wr_ptr_q]  <= push_op_i;
      rd_mem[wr_ptr_q]  <= push_rd_i;
      alu_mem[wr_ptr_q] <= push_alu_i;
      rs2_mem[wr_ptr_q] <= push_rs2_i;
    end
  end

  // pointers wrap at the depth, which need not be a power of two
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        if (wr_ptr_q == (`LSU_IN_PTR_W)'(`LSU_IN_DEPTH - 1)) wr_ptr_q <= '0;
        else wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        if (rd_ptr_q == (`LSU_IN_PTR_W)'(`LSU_IN_DEPTH - 1)) rd_ptr_q <= '0;
        else rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      // push and pop together leave the count alone
      count_q <= count_q + (`LSU_IN_CNT_W)'(push_i) - (`LSU_IN_CNT_W)'(pop_ok);
    end
  end

endmodule

// ==== design/mem_req_stage.sv ====
`timescale 1ns/1ps
`include "lsu_macros.svh"

module mem_req_stage (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic                   q_valid_i,
  input  lsu_pkg::mem_op_e       q_op_i,
  input  logic [`LSU_REG_W-1:0]  q_rd_i,
  input  logic [`LSU_XLEN-1:0]   q_alu_i,
  input  logic [`LSU_XLEN-1:0]   q_rs2_i,
  output logic                   q_pop_o,
  input  logic                   wb_slot_free_i,
  output logic [`LSU_ADDR_W-1:0] mem_addr_o,
  output logic                   mem_addr_valid_o,
  output logic [7:0]             mem_mask_o,
  output logic                   mem_write_o,
  output logic [`LSU_XLEN-1:0]   mem_wdata_o,
  input  logic                   mem_data_ready_i,
  input  logic [`LSU_XLEN-1:0]   mem_rdata_i,
  output logic                   res_valid_o,
  output lsu_pkg::mem_op_e       res_op_o,
  output logic [`LSU_REG_W-1:0]  res_rd_o,
  output logic [2:0]             res_off_o,
  output logic [`LSU_XLEN-1:0]   res_alu_o,
  output logic [`LSU_XLEN-1:0]   res_rdata_o
);
  import lsu_pkg::*;

  req_state_e             state_q;
  mem_op_e                op_q;
  logic [`LSU_REG_W-1:0]  rd_q;
  logic [`LSU_XLEN-1:0]   alu_q;
  logic [`LSU_XLEN-1:0]   rs2_q;
  logic                   in_wait;
  logic                   take;
  logic                   head_is_mem;
  logic                   is_store;
  logic [7:0]             size_mask;
  logic [`LSU_XLEN-1:0]   wdata_raw;
  logic [2:0]             off;

  assign in_wait     = (state_q == REQ_WAIT);
  assign head_is_mem = (q_op_i != MEMOP_NONE);
  // take the head only with a free writeback slot
  assign take    = ~in_wait & q_valid_i & wb_slot_free_i;
  assign q_pop_o = take;

  // width class and direction of the held op
  // store data keeps only the low bytes of rs2
  always_comb begin
    is_store  = 1'b0;
    size_mask = 8'h00;
    wdata_raw = '0;
    case (op_q)
      MEMOP_LB, MEMOP_LBU: size_mask = 8'h01;
      MEMOP_LH, MEMOP_LHU: size_mask = 8'h03;
      MEMOP_LW, MEMOP_LWU: size_mask = 8'h0f;
      MEMOP_LD:            size_mask = 8'hff;
      MEMOP_SB: begin
        is_store  = 1'b1;
        size_mask = 8'h01;
        wdata_raw = {{(`LSU_XLEN-8){1'b0}}, rs2_q[7:0]};
      end
      MEMOP_SH: begin
        is_store  = 1'b1;
        size_mask = 8'h03;
        wdata_raw = {{(`LSU_XLEN-16){1'b0}}, rs2_q[15:0]};
      end
      MEMOP_SW: begin
        is_store  = 1'b1;
        size_mask = 8'h0f;
        wdata_raw = {{(`LSU_XLEN-32){1'b0}}, rs2_q[31:0]};
      end
      MEMOP_SD: begin
        is_store  = 1'b1;
        size_mask = 8'hff;
        wdata_raw = rs2_q;
      end
      default: ;
    endcase
  end

  // byte offset inside the 64-bit word
  assign off = alu_q[2:0];

  // request held until the ram answers, dropped in the ready cycle
  assign mem_addr_valid_o = in_wait & ~mem_data_ready_i;
  assign mem_write_o      = mem_addr_valid_o & is_store;
  assign mem_addr_o       = alu_q[`LSU_ADDR_W-1:0];
  // mask and data moved to the byte lane of the access
  assign mem_mask_o       = size_mask << off;
  assign mem_wdata_o      = wdata_raw << {off, 3'b000};

  // memory ops answer on ready, none ops on the take cycle
  assign res_valid_o = (take & ~head_is_mem) | (in_wait & mem_data_ready_i);
  assign res_op_o    = in_wait ? op_q : q_op_i;
  assign res_rd_o    = in_wait ? rd_q : q_rd_i;
  assign res_alu_o   = in_wait ? alu_q : q_alu_i;
  assign res_off_o   = in_wait ? off : q_alu_i[2:0];
  // raw word, extraction happens in writeback
  assign res_rdata_o = (in_wait & mem_data_ready_i) ? mem_rdata_i : '0;

  // latch the head as it leaves the queue
  always_ff @(posedge clk) begin
    if (take) begin
      op_q  <= q_op_i;
      rd_q  <= q_rd_i;
      alu_q <= q_alu_i;
      rs2_q <= q_rs2_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= REQ_IDLE;
    end else begin
      case (state_q)
        REQ_IDLE: if (take & head_is_mem) state_q <= REQ_WAIT;
        REQ_WAIT: if (mem_data_ready_i) state_q <= REQ_IDLE;
        default:  state_q <= REQ_IDLE;
      endcase
    end
  end

endmodule

// ==== design/data_ram.sv ====
`timescale 1ns/1ps
`include "lsu_macros.svh"

module data_ram (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic [`LSU_ADDR_W-1:0] mem_addr_i,
  input  logic                   mem_addr_valid_i,
  input  logic [7:0]             mem_mask_i,
  input  logic                   mem_write_i,
  input  logic [`LSU_XLEN-1:0]   mem_wdata_i,
  output logic                   mem_data_ready_o,
  output logic [`LSU_XLEN-1:0]   mem_rdata_o
);
  import lsu_pkg::*;

  ram_state_e                state_q;
  logic [`LSU_XLEN-1:0]      mem_q [`LSU_RAM_WORDS];
  logic [`LSU_RAM_IDX_W-1:0] idx_in;
  logic [`LSU_RAM_IDX_W-1:0] idx_q;
  logic [`LSU_XLEN-1:0]      rdata_q;
  logic                      accept;

  // word index sits above the byte offset
  // high address bits beyond the depth wrap
  assign idx_in = mem_addr_i[3 +: `LSU_RAM_IDX_W];
  assign accept = (state_q == RAM_IDLE) & mem_addr_valid_i;

  // ready two cycles after the request is accepted
  assign mem_data_ready_o = (state_q == RAM_RESP);
  assign mem_rdata_o      = rdata_q;

  // store lands in the accept cycle, only masked bytes
  always_ff @(posedge clk) begin
    if (accept & mem_write_i) begin
      for (int b = 0; b < 8; b++) begin
        if (mem_mask_i[b]) mem_q[idx_in][b*8 +: 8] <= mem_wdata_i[b*8 +: 8];
      end
    end
  end

  // address kept for the read in the busy cycle
  always_ff @(posedge clk) begin
    if (accept) idx_q <= idx_in;
  end

  // whole word read, so a store sees its own update
  always_ff @(posedge clk) begin
    if (state_q == RAM_BUSY) rdata_q <= mem_q[idx_q];
  end

  // idle -> busy -> resp -> idle
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= RAM_IDLE;
    end else begin
      case (state_q)
        RAM_IDLE: if (accept) state_q <= RAM_BUSY;
        RAM_BUSY: state_q <= RAM_RESP;
        RAM_RESP: state_q <= RAM_IDLE;
        default:  state_q <= RAM_IDLE;
      endcase
    end
  end

endmodule

// ==== design/load_wb_stage.sv ====
`timescale 1ns/1ps
`include "lsu_macros.svh"

module load_wb_stage (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  res_valid_i,
  input  lsu_pkg::mem_op_e      res_op_i,
  input  logic [`LSU_REG_W-1:0] res_rd_i,
  input  logic [2:0]            res_off_i,
  input  logic [`LSU_XLEN-1:0]  res_alu_i,
  input  logic [`LSU_XLEN-1:0]  res_rdata_i,
  output logic                  wb_slot_free_o,
  output logic                  wb_valid_o,
  output logic [`LSU_REG_W-1:0] wb_rd_o,
  output logic [`LSU_XLEN-1:0]  wb_data_o,
  input  logic                  wb_credit_i
);
  import lsu_pkg::*;

  logic                     held_q;
  logic [`LSU_WB_CNT_W-1:0] credit_q;
  logic [`LSU_REG_W-1:0]    rd_q;
  logic [`LSU_XLEN-1:0]     data_q;
  logic [`LSU_XLEN-1:0]     shifted;
  logic [`LSU_XLEN-1:0]     result;
  logic                     send_now;

  // addressed bytes down to bit zero
  assign shifted = res_rdata_i >> {res_off_i, 3'b000};

  // sign or zero extension per load kind
  // stores and none ops write back the alu value
  always_comb begin
    case (res_op_i)
      MEMOP_LB:  result = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
      MEMOP_LBU: result = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
      MEMOP_LH:  result = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
      MEMOP_LHU: result = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
      MEMOP_LW:  result = {{(`LSU_XLEN-32){shifted[31]}}, shifted[31:0]};
      MEMOP_LWU: result = {{(`LSU_XLEN-32){1'b0}}, shifted[31:0]};
      MEMOP_LD:  result = shifted;
      default:   result = res_alu_i;
    endcase
  end

  // held result goes out as soon as a credit is there
  assign send_now   = held_q & (credit_q != '0);
  assign wb_valid_o = send_now;
  assign wb_rd_o    = rd_q;
  assign wb_data_o  = data_q;
  // slot reusable in the same cycle it drains
  assign wb_slot_free_o = ~held_q | send_now;

  // result register, loaded one cycle after res_valid
  always_ff @(posedge clk) begin
    if (res_valid_i) begin
      rd_q   <= res_rd_i;
      data_q <= result;
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      held_q   <= 1'b0;
      credit_q <= (`LSU_WB_CNT_W)'(`LSU_WB_CREDITS);
    end else begin
      // request side only sends into a free slot
      if (res_valid_i) held_q <= 1'b1;
      else if (send_now) held_q <= 1'b0;
      // spend one per result, regain one per consumer pulse
      case ({send_now, wb_credit_i})
        2'b10:   credit_q <= credit_q - 1'b1;
        2'b01:   credit_q <= credit_q + 1'b1;
        default: ;
      endcase
    end
  end

endmodule

// ==== design/lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_top (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  ex_valid_i,
  input  lsu_pkg::mem_op_e      ex_op_i,
  input  logic [`LSU_REG_W-1:0] ex_rd_i,
  input  logic [`LSU_XLEN-1:0]  ex_alu_i,
  input  logic [`LSU_XLEN-1:0]  ex_rs2_i,
  output logic                  ex_credit_o,
  output logic                  wb_valid_o,
  output logic [`LSU_REG_W-1:0] wb_rd_o,
  output logic [`LSU_XLEN-1:0]  wb_data_o,
  input  logic                  wb_credit_i
);
  import lsu_pkg::*;

  // queue head
  logic                   q_valid;
  mem_op_e                q_op;
  logic [`LSU_REG_W-1:0]  q_rd;
  logic [`LSU_XLEN-1:0]   q_alu;
  logic [`LSU_XLEN-1:0]   q_rs2;
  logic                   q_pop;
  // ram request and response
  logic [`LSU_ADDR_W-1:0] mem_addr;
  logic                   mem_addr_valid;
  logic [7:0]             mem_mask;
  logic                   mem_write;
  logic [`LSU_XLEN-1:0]   mem_wdata;
  logic                   mem_data_ready;
  logic [`LSU_XLEN-1:0]   mem_rdata;
  // raw result into writeback
  logic                   res_valid;
  mem_op_e                res_op;
  logic [`LSU_REG_W-1:0]  res_rd;
  logic [2:0]             res_off;
  logic [`LSU_XLEN-1:0]   res_alu;
  logic [`LSU_XLEN-1:0]   res_rdata;
  logic                   wb_slot_free;

  lsu_in_fifo u_in_fifo (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .push_i     (ex_valid_i),
    .push_op_i  (ex_op_i),
    .push_rd_i  (ex_rd_i),
    .push_alu_i (ex_alu_i),
    .push_rs2_i (ex_rs2_i),
    .pop_i      (q_pop),
    .valid_o    (q_valid),
    .op_o       (q_op),
    .rd_o       (q_rd),
    .alu_o      (q_alu),
    .rs2_o      (q_rs2),
    .credit_o   (ex_credit_o)
  );

  mem_req_stage u_mem_req (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .q_valid_i        (q_valid),
    .q_op_i           (q_op),
    .q_rd_i           (q_rd),
    .q_alu_i          (q_alu),
    .q_rs2_i          (q_rs2),
    .q_pop_o          (q_pop),
    .wb_slot_free_i   (wb_slot_free),
    .mem_addr_o       (mem_addr),
    .mem_addr_valid_o (mem_addr_valid),
    .mem_mask_o       (mem_mask),
    .mem_write_o      (mem_write),
    .mem_wdata_o      (mem_wdata),
    .mem_data_ready_i (mem_data_ready),
    .mem_rdata_i      (mem_rdata),
    .res_valid_o      (res_valid),
    .res_op_o         (res_op),
    .res_rd_o         (res_rd),
    .res_off_o        (res_off),
    .res_alu_o        (res_alu),
    .res_rdata_o      (res_rdata)
  );

  data_ram u_data_ram (
    .clk              (clk),
    .rst_n_i          (rst_n_i),
    .mem_addr_i       (mem_addr),
    .mem_addr_valid_i (mem_addr_valid),
    .mem_mask_i       (mem_mask),
    .mem_write_i      (mem_write),
    .mem_wdata_i      (mem_wdata),
    .mem_data_ready_o (mem_data_ready),
    .mem_rdata_o      (mem_rdata)
  );

  load_wb_stage u_load_wb (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .res_valid_i    (res_valid),
    .res_op_i       (res_op),
    .res_rd_i       (res_rd),
    .res_off_i      (res_off),
    .res_alu_i      (res_alu),
    .res_rdata_i    (res_rdata),
    .wb_slot_free_o (wb_slot_free),
    .wb_valid_o     (wb_valid_o),
    .wb_rd_o        (wb_rd_o),
    .wb_data_o      (wb_data_o),
    .wb_credit_i    (wb_credit_i)
  );

endmodule

// ==== sim/lsu_tb_checks.sv ====
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_tb_checks (
  input  logic                  clk,
  input  logic                  rst_n_i,
  input  logic                  ex_valid_i,
  input  logic                  ex_credit_i,
  input  logic                  wb_valid_i,
  input  logic [`LSU_REG_W-1:0] wb_rd_i,
  input  logic [`LSU_XLEN-1:0]  wb_data_i,
  input  logic                  wb_credit_i,
  input  logic                  exp_push_i,
  input  logic [`LSU_REG_W-1:0] exp_rd_i,
  input  logic [`LSU_XLEN-1:0]  exp_data_i,
  input  logic                  end_i,
  output int                    results_o,
  output int                    value_errs_o,
  output int                    proto_errs_o
);

  // expected results in op order
  logic [`LSU_REG_W-1:0] rd_fifo [$];
  logic [`LSU_XLEN-1:0]  data_fifo [$];
  logic [`LSU_REG_W-1:0] head_rd;
  logic [`LSU_XLEN-1:0]  head_data;
  int                    sent_cnt;
  int                    credit_cnt;
  // mirror of the credits the dut holds downstream
  int                    wb_credits;
  bit                    first_seen;

  always @(posedge clk) begin
    if (!rst_n_i) begin
      sent_cnt     = 0;
      credit_cnt   = 0;
      wb_credits   = `LSU_WB_CREDITS;
      first_seen   = 1'b0;
      value_errs_o = 0;
      proto_errs_o = 0;
      results_o   <= 0;
    end else begin
      if (ex_credit_i) credit_cnt++;
      // quiet outputs until execute sends something
      if (!first_seen) begin
        assert (!ex_credit_i && !wb_valid_i) else begin
          $display("%0t: credit or result output active before any op was sent", $time);
          proto_errs_o++;
        end
      end
      if (ex_valid_i) begin
        sent_cnt++;
        first_seen = 1'b1;
      end
      // queue occupancy bounded by its depth
      assert (sent_cnt - credit_cnt <= `LSU_IN_DEPTH) else begin
        $display("%0t: more than %0d ops outstanding upstream", $time, `LSU_IN_DEPTH);
        proto_errs_o++;
      end
      assert (credit_cnt <= sent_cnt) else begin
        $display("%0t: more upstream credits returned than ops sent", $time);
        proto_errs_o++;
      end
      if (exp_push_i) begin
        rd_fifo.push_back(exp_rd_i);
        data_fifo.push_back(exp_data_i);
      end
      if (wb_valid_i) begin
        results_o <= results_o + 1;
        // never more results than credits granted
        assert (wb_credits > 0) else begin
          $display("%0t: wb_valid_o high while the dut holds no credit", $time);
          proto_errs_o++;
        end
        assert (data_fifo.size() != 0) else begin
          $display("%0t: result on wb_valid_o with no op outstanding", $time);
          proto_errs_o++;
        end
        if (data_fifo.size() != 0) begin
          head_rd   = rd_fifo.pop_front();
          head_data = data_fifo.pop_front();
          assert (wb_rd_i == head_rd) else begin
            $display("[ERROR] %0t wb_rd_o got %0d expected %0d", $time, wb_rd_i, head_rd);
            value_errs_o++;
          end
          assert (wb_data_i == head_data) else begin
            $display("[ERROR] %0t wb_data_o got %h expected %h", $time, wb_data_i, head_data);
            value_errs_o++;
          end
        end
      end
      wb_credits = wb_credits - int'(wb_valid_i) + int'(wb_credit_i);
      // end of run with everything accounted for
      if (end_i) begin
        assert (data_fifo.size() == 0) else begin
          $display("%0t: %0d results never arrived", $time, data_fifo.size());
          proto_errs_o++;
        end
        assert (credit_cnt == sent_cnt) else begin
          $display("%0t: %0d credit pulses for %0d ops sent", $time, credit_cnt, sent_cnt);
          proto_errs_o++;
        end
      end
    end
  end

endmodule

// ==== sim/lsu_tb.sv ====
`timescale 1ns/1ps
`include "lsu_macros.svh"

module lsu_tb;
  import lsu_pkg::*;

  logic                  clk;
  logic                  rst_n;
  logic                  ex_valid;
  mem_op_e               ex_op;
  logic [`LSU_REG_W-1:0] ex_rd;
  logic [`LSU_XLEN-1:0]  ex_alu;
  logic [`LSU_XLEN-1:0]  ex_rs2;
  logic                  ex_credit;
  logic                  wb_valid;
  logic [`LSU_REG_W-1:0] wb_rd;
  logic [`LSU_XLEN-1:0]  wb_data;
  logic                  wb_credit;
  // expected result handed to the checker
  logic                  exp_push;
  logic [`LSU_REG_W-1:0] exp_rd;
  logic [`LSU_XLEN-1:0]  exp_data;
  logic                  end_check;
  int                    results;
  int                    value_errs;
  int                    proto_errs;

  // byte model of the ram region under test
  logic [7:0] mem_model [2048];
  mem_op_e    store_ops [4] = '{MEMOP_SB, MEMOP_SH, MEMOP_SW, MEMOP_SD};
  mem_op_e    load_ops  [7] = '{MEMOP_LB, MEMOP_LBU, MEMOP_LH, MEMOP_LHU,
                                MEMOP_LW, MEMOP_LWU, MEMOP_LD};
  int         seed;
  int         ops_sent;
  int         up_credits;
  // results the consumer still owes a credit for
  int         wb_pending;
  int         cycles;
  bit         withhold;

  lsu_top u_dut (
    .clk         (clk),
    .rst_n_i     (rst_n),
    .ex_valid_i  (ex_valid),
    .ex_op_i     (ex_op),
    .ex_rd_i     (ex_rd),
    .ex_alu_i    (ex_alu),
    .ex_rs2_i    (ex_rs2),
    .ex_credit_o (ex_credit),
    .wb_valid_o  (wb_valid),
    .wb_rd_o     (wb_rd),
    .wb_data_o   (wb_data),
    .wb_credit_i (wb_credit)
  );

  lsu_tb_checks u_checks (
    .clk          (clk),
    .rst_n_i      (rst_n),
    .ex_valid_i   (ex_valid),
    .ex_credit_i  (ex_credit),
    .wb_valid_i   (wb_valid),
    .wb_rd_i      (wb_rd),
    .wb_data_i    (wb_data),
    .wb_credit_i  (wb_credit),
    .exp_push_i   (exp_push),
    .exp_rd_i     (exp_rd),
    .exp_data_i   (exp_data),
    .end_i        (end_check),
    .results_o    (results),
    .value_errs_o (value_errs),
    .proto_errs_o (proto_errs)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // watchdog, limit grows by 40 cycles per op sent
  initial begin
    cycles = 0;
    while (cycles <= 40 * ops_sent + 200) begin
      @(negedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d of %0d results seen", cycles, results, ops_sent);
    $display("Checks failed");
    $finish;
  end

  function automatic int access_size(mem_op_e op);
    case (op)
      MEMOP_LB, MEMOP_LBU, MEMOP_SB: return 1;
      MEMOP_LH, MEMOP_LHU, MEMOP_SH: return 2;
      MEMOP_LW, MEMOP_LWU, MEMOP_SW: return 4;
      MEMOP_LD, MEMOP_SD:            return 8;
      default:                       return 0;
    endcase
  endfunction

  // little endian gather from the model, then extend
  function automatic logic [63:0] load_value(mem_op_e op, logic [10:0] addr);
    logic [63:0] raw;
    int          n;
    raw = '0;
    n   = access_size(op);
    for (int i = 0; i < n; i++) raw[i*8 +: 8] = mem_model[addr + 11'(i)];
    if ((op inside {MEMOP_LB, MEMOP_LH, MEMOP_LW}) && raw[n*8-1]) begin
      for (int i = n * 8; i < 64; i++) raw[i] = 1'b1;
    end
    return raw;
  endfunction

  function automatic logic [63:0] random_word();
    return {$random(seed), $random(seed)};
  endfunction

  // naturally aligned address inside one of the eight test words
  function automatic logic [63:0] pick_addr(mem_op_e op, int word);
    int n;
    int off;
    n   = (access_size(op) == 0) ? 1 : access_size(op);
    off = ($unsigned($random(seed)) % 8) / n * n;
    return 64'h100 + 64'(word * 8 + off);
  endfunction

  // one clock edge: credit bookkeeping both sides, default drives
  task automatic tick();
    @(posedge clk);
    if (ex_credit) up_credits++;
    if (wb_valid) wb_pending++;
    ex_valid  <= 1'b0;
    exp_push  <= 1'b0;
    wb_credit <= 1'b0;
    // consumer frees results after random gaps
    if (!withhold && wb_pending > 0 && (($random(seed) & 1) == 0)) begin
      wb_credit <= 1'b1;
      wb_pending--;
    end
  endtask

  task automatic send_op(mem_op_e op, logic [`LSU_REG_W-1:0] rd, logic [63:0] alu,
                         logic [63:0] rs2);
    logic [63:0] expect_val;
    tick();
    while (up_credits == 0) tick();
    // loads read the model, everything else returns the alu value
    if (op inside {MEMOP_LB, MEMOP_LBU, MEMOP_LH, MEMOP_LHU, MEMOP_LW, MEMOP_LWU, MEMOP_LD})
      expect_val = load_value(op, alu[10:0]);
    else
      expect_val = alu;
    if (op inside {MEMOP_SB, MEMOP_SH, MEMOP_SW, MEMOP_SD}) begin
      for (int i = 0; i < access_size(op); i++) mem_model[alu[10:0] + 11'(i)] = rs2[i*8 +: 8];
    end
    ex_valid   <= 1'b1;
    ex_op      <= op;
    ex_rd      <= rd;
    ex_alu     <= alu;
    ex_rs2     <= rs2;
    exp_push   <= 1'b1;
    exp_rd     <= rd;
    exp_data   <= expect_val;
    up_credits--;
    ops_sent++;
  endtask

  task automatic send_random_op();
    mem_op_e               op;
    logic [`LSU_REG_W-1:0] rd;
    op = mem_op_e'(4'($unsigned($random(seed)) % 12));
    rd = `LSU_REG_W'($unsigned($random(seed)));
    if (op == MEMOP_NONE) send_op(op, rd, random_word(), random_word());
    else send_op(op, rd, pick_addr(op, $unsigned($random(seed)) % 8), random_word());
  endtask

  // wait for every result and every credit return
  task automatic drain();
    tick();
    while (results != ops_sent || wb_pending != 0) tick();
    repeat (3) tick();
  endtask

  initial begin
    seed       = 54;
    ops_sent   = 0;
    up_credits = `LSU_IN_DEPTH;
    wb_pending = 0;
    withhold   = 1'b0;
    rst_n      = 1'b0;
    ex_valid   = 1'b0;
    ex_op      = MEMOP_NONE;
    ex_rd      = '0;
    ex_alu     = '0;
    ex_rs2     = '0;
    wb_credit  = 1'b0;
    exp_push   = 1'b0;
    exp_rd     = '0;
    exp_data   = '0;
    end_check  = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    // idle stretch, outputs must stay low
    repeat (6) tick();
    // every test word gets defined contents first
    for (int w = 0; w < 8; w++) send_op(MEMOP_SD, `LSU_REG_W'(w + 1), 64'h100 + 64'(w * 8),
                                        random_word());
    // each store width at each aligned offset, then all seven loads
    for (int s = 0; s < 4; s++) begin
      for (int off = 0; off < 8; off = off + access_size(store_ops[s])) begin
        send_op(store_ops[s], `LSU_REG_W'(s + 9), 64'h100 + 64'(s * 8 + off), random_word());
        for (int l = 0; l < 7; l++) begin
          send_op(load_ops[l], `LSU_REG_W'($unsigned($random(seed))),
                  pick_addr(load_ops[l], s), 64'h0);
        end
      end
    end
    drain();
    // mixed stream with none ops
    repeat (40) send_random_op();
    drain();
    // consumer holds its credits, queue backs up
    withhold = 1'b1;
    repeat (6) send_random_op();
    repeat (30) tick();
    withhold = 1'b0;
    repeat (10) send_random_op();
    drain();
    end_check <= 1'b1;
    tick();
    end_check <= 1'b0;
    repeat (2) tick();
    $display("errors: %0d value, %0d protocol, %0d results for %0d ops",
             value_errs, proto_errs, results, ops_sent);
    if (value_errs == 0 && proto_errs == 0)
      $display("All checks passed");
    else
      $display("Checks failed");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+design
design/lsu_pkg.sv
design/lsu_in_fifo.sv
design/mem_req_stage.sv
design/data_ram.sv
design/load_wb_stage.sv
design/lsu_top.sv
sim/lsu_tb_checks.sv
sim/lsu_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the lsu testbench with verilator and runs it
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -Wno-fatal -f project.f --top-module lsu_tb -o lsu_sim

./obj_dir/lsu_sim | tee sim.log

if grep -q "Checks failed" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi

echo "simulation passed"
exit 0
